// ==== logic/grid_pkg.sv ====
// Grid package
// Dimensions, field widths and flit format shared by every block of the
// 3x3 torus interconnect

package grid_pkg;

  //////////////////////////////////////////////////
  // Grid size
  //////////////////////////////////////////////////

  localparam int GRID_ROWS  = 3;
  localparam int GRID_COLS  = 3;
  localparam int GRID_NODES = GRID_ROWS * GRID_COLS;

  //////////////////////////////////////////////////
  // Field widths and buffering
  //////////////////////////////////////////////////

  localparam int ROW_W      = $clog2(GRID_ROWS);
  localparam int COL_W      = $clog2(GRID_COLS);
  localparam int PAYLOAD_W  = 16;

  // Entries per ring input buffer
  localparam int LINK_DEPTH = 2;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Node number is row * GRID_COLS + col
  typedef struct packed {
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
  } node_id_t;

  typedef struct packed {
    node_id_t             dst;
    node_id_t             src;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

// ==== logic/grid_link_buf.sv ====
// Ring link buffer
// Small valid/ready FIFO at the input of each ring link; output side is
// taken straight from storage so every hop costs one cycle

`timescale 1ns/100ps

module grid_link_buf (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            in_valid_i,
  input  grid_pkg::flit_t in_flit_i,
  output logic            in_ready_o,
  output logic            out_valid_o,
  output grid_pkg::flit_t out_flit_o,
  input  logic            out_ready_i
);
  import grid_pkg::*;

  flit_t                           mem [LINK_DEPTH];
  logic [$clog2(LINK_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(LINK_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(LINK_DEPTH+1)-1:0] count;
  logic                            push;
  logic                            pop;

  // Wrapping pointer increment
  function automatic logic [$clog2(LINK_DEPTH)-1:0] next_ptr(
    input logic [$clog2(LINK_DEPTH)-1:0] ptr
  );
    if (ptr == LINK_DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Ready only depends on fill level
  assign in_ready_o  = (count != LINK_DEPTH);
  assign out_valid_o = (count != '0);
  assign out_flit_o  = mem[rd_ptr];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  //////////////////////////////////////////////////
  // Pointers and fill count
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

endmodule

// ==== logic/grid_node_switch.sv ====
// Node switch
// Dimension-ordered route selection and fixed-priority arbitration
// between the two ring inputs and the local injection port

`timescale 1ns/100ps

module grid_node_switch (
  input  grid_pkg::node_id_t my_id_i,

  input  logic               h_in_valid_i,
  input  grid_pkg::flit_t    h_in_flit_i,
  output logic               h_in_ready_o,

  input  logic               v_in_valid_i,
  input  grid_pkg::flit_t    v_in_flit_i,
  output logic               v_in_ready_o,

  input  logic               loc_in_valid_i,
  input  grid_pkg::flit_t    loc_in_flit_i,
  output logic               loc_in_ready_o,

  output logic               h_out_valid_o,
  output grid_pkg::flit_t    h_out_flit_o,
  input  logic               h_out_ready_i,

  output logic               v_out_valid_o,
  output grid_pkg::flit_t    v_out_flit_o,
  input  logic               v_out_ready_i,

  output logic               ej_valid_o,
  output grid_pkg::flit_t    ej_flit_o,
  input  logic               ej_ready_i
);
  import grid_pkg::*;

  // Output vectors are one-hot, bit 0 row ring, bit 1 column ring, bit 2 eject
  logic [2:0] h_sel;
  logic [2:0] v_sel;
  logic [2:0] loc_sel;
  logic [2:0] h_req;
  logic [2:0] v_req;
  logic [2:0] loc_req;
  logic [2:0] h_gnt;
  logic [2:0] v_gnt;
  logic [2:0] loc_gnt;
  logic [2:0] out_ready;
  logic [2:0] out_valid;

  //////////////////////////////////////////////////
  // Route selection
  //////////////////////////////////////////////////

  // Row ring first, then column ring, then eject
  function automatic logic [2:0] route_sel(input flit_t flit, input node_id_t here);
    logic [2:0] sel;
    sel = 3'b000;
    if (flit.dst.col != here.col) begin
      sel[0] = 1'b1;
    end else if (flit.dst.row != here.row) begin
      sel[1] = 1'b1;
    end else begin
      sel[2] = 1'b1;
    end
    return sel;
  endfunction

  // Data for one output, highest priority requester wins
  function automatic flit_t pick(
    input logic  v_hit,
    input logic  h_hit,
    input flit_t v_flit,
    input flit_t h_flit,
    input flit_t loc_flit
  );
    if (v_hit) begin
      return v_flit;
    end
    if (h_hit) begin
      return h_flit;
    end
    return loc_flit;
  endfunction

  // Route is known even without valid so ready can be offered early
  assign h_sel   = route_sel(h_in_flit_i, my_id_i);
  assign v_sel   = route_sel(v_in_flit_i, my_id_i);
  assign loc_sel = route_sel(loc_in_flit_i, my_id_i);

  assign h_req   = h_sel & {3{h_in_valid_i}};
  assign v_req   = v_sel & {3{v_in_valid_i}};
  assign loc_req = loc_sel & {3{loc_in_valid_i}};

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  // Fixed priority: column ring, row ring, local
  assign v_gnt   = v_sel;
  assign h_gnt   = h_sel & ~v_req;
  assign loc_gnt = loc_sel & ~v_req & ~h_req;

  assign out_ready = {ej_ready_i, v_out_ready_i, h_out_ready_i};
  assign out_valid = v_req | h_req | loc_req;

  assign v_in_ready_o   = |(v_gnt & out_ready);
  assign h_in_ready_o   = |(h_gnt & out_ready);
  assign loc_in_ready_o = |(loc_gnt & out_ready);

  //////////////////////////////////////////////////
  // Output muxes
  //////////////////////////////////////////////////

  assign h_out_valid_o = out_valid[0];
  assign v_out_valid_o = out_valid[1];
  assign ej_valid_o    = out_valid[2];

  always_comb begin
    h_out_flit_o = pick(v_req[0], h_req[0], v_in_flit_i, h_in_flit_i, loc_in_flit_i);
    v_out_flit_o = pick(v_req[1], h_req[1], v_in_flit_i, h_in_flit_i, loc_in_flit_i);
    ej_flit_o    = pick(v_req[2], h_req[2], v_in_flit_i, h_in_flit_i, loc_in_flit_i);
  end

endmodule

// ==== logic/grid_node.sv ====
// Routing node
// Buffers both ring inputs, builds the local flit from the injection port
// and its own position, and splits the ejected flit back into fields

`timescale 1ns/100ps

module grid_node #(
  parameter int ROW = 0,
  parameter int COL = 0
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  input  logic                             h_in_valid_i,
  input  grid_pkg::flit_t                  h_in_flit_i,
  output logic                             h_in_ready_o,
  input  logic                             v_in_valid_i,
  input  grid_pkg::flit_t                  v_in_flit_i,
  output logic                             v_in_ready_o,

  output logic                             h_out_valid_o,
  output grid_pkg::flit_t                  h_out_flit_o,
  input  logic                             h_out_ready_i,
  output logic                             v_out_valid_o,
  output grid_pkg::flit_t                  v_out_flit_o,
  input  logic                             v_out_ready_i,

  input  logic                             inj_valid_i,
  input  grid_pkg::node_id_t               inj_dst_i,
  input  logic [grid_pkg::PAYLOAD_W-1:0]   inj_payload_i,
  output logic                             inj_ready_o,

  output logic                             ej_valid_o,
  output grid_pkg::node_id_t               ej_src_o,
  output logic [grid_pkg::PAYLOAD_W-1:0]   ej_payload_o,
  input  logic                             ej_ready_i
);
  import grid_pkg::*;

  node_id_t my_id;
  flit_t    loc_flit;
  flit_t    ej_flit;
  logic     h_head_valid;
  flit_t    h_head_flit;
  logic     h_head_ready;
  logic     v_head_valid;
  flit_t    v_head_flit;
  logic     v_head_ready;

  assign my_id.row = ROW_W'(ROW);
  assign my_id.col = COL_W'(COL);

  // Source field is always this node
  assign loc_flit.dst     = inj_dst_i;
  assign loc_flit.src     = my_id;
  assign loc_flit.payload = inj_payload_i;

  assign ej_src_o     = ej_flit.src;
  assign ej_payload_o = ej_flit.payload;

  //////////////////////////////////////////////////
  // Ring input buffers
  //////////////////////////////////////////////////

  grid_link_buf u_h_buf (
    .clk_i,
    .rst_n_i,
    .in_valid_i (h_in_valid_i),
    .in_flit_i  (h_in_flit_i),
    .in_ready_o (h_in_ready_o),
    .out_valid_o(h_head_valid),
    .out_flit_o (h_head_flit),
    .out_ready_i(h_head_ready)
  );

  grid_link_buf u_v_buf (
    .clk_i,
    .rst_n_i,
    .in_valid_i (v_in_valid_i),
    .in_flit_i  (v_in_flit_i),
    .in_ready_o (v_in_ready_o),
    .out_valid_o(v_head_valid),
    .out_flit_o (v_head_flit),
    .out_ready_i(v_head_ready)
  );

  //////////////////////////////////////////////////
  // Switch
  //////////////////////////////////////////////////

  grid_node_switch u_switch (
    .my_id_i       (my_id),
    .h_in_valid_i  (h_head_valid),
    .h_in_flit_i   (h_head_flit),
    .h_in_ready_o  (h_head_ready),
    .v_in_valid_i  (v_head_valid),
    .v_in_flit_i   (v_head_flit),
    .v_in_ready_o  (v_head_ready),
    .loc_in_valid_i(inj_valid_i),
    .loc_in_flit_i (loc_flit),
    .loc_in_ready_o(inj_ready_o),
    .h_out_valid_o (h_out_valid_o),
    .h_out_flit_o  (h_out_flit_o),
    .h_out_ready_i (h_out_ready_i),
    .v_out_valid_o (v_out_valid_o),
    .v_out_flit_o  (v_out_flit_o),
    .v_out_ready_i (v_out_ready_i),
    .ej_valid_o    (ej_valid_o),
    .ej_flit_o     (ej_flit),
    .ej_ready_i    (ej_ready_i)
  );

endmodule

// ==== logic/grid_torus.sv ====
// Torus interconnect top
// 3x3 array of routing nodes; each row and each column is closed into a
// one-way ring, and every node has its own injection and ejection port

`timescale 1ns/100ps

module grid_torus (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  input  logic                           inj_valid_i  [grid_pkg::GRID_NODES],
  input  grid_pkg::node_id_t             inj_dst_i    [grid_pkg::GRID_NODES],
  input  logic [grid_pkg::PAYLOAD_W-1:0] inj_payload_i[grid_pkg::GRID_NODES],
  output logic                           inj_ready_o  [grid_pkg::GRID_NODES],

  output logic                           ej_valid_o   [grid_pkg::GRID_NODES],
  output grid_pkg::node_id_t             ej_src_o     [grid_pkg::GRID_NODES],
  output logic [grid_pkg::PAYLOAD_W-1:0] ej_payload_o [grid_pkg::GRID_NODES],
  input  logic                           ej_ready_i   [grid_pkg::GRID_NODES]
);
  import grid_pkg::*;

  //////////////////////////////////////////////////
  // Ring links, indexed by the sending node
  //////////////////////////////////////////////////

  logic  h_valid[GRID_NODES];
  flit_t h_flit [GRID_NODES];
  logic  h_ready[GRID_NODES];

  logic  v_valid[GRID_NODES];
  flit_t v_flit [GRID_NODES];
  logic  v_ready[GRID_NODES];

  //////////////////////////////////////////////////
  // Node array
  //////////////////////////////////////////////////

  // Row ring input comes from the node one column back, column ring input
  // from the node one row back, both wrapping at the edge
  for (genvar row = 0; row < GRID_ROWS; row++) begin : gen_row
    for (genvar col = 0; col < GRID_COLS; col++) begin : gen_col
      grid_node #(
        .ROW(row),
        .COL(col)
      ) u_node (
        .clk_i,
        .rst_n_i,
        .h_in_valid_i (h_valid[row * GRID_COLS + (col + GRID_COLS - 1) % GRID_COLS]),
        .h_in_flit_i  (h_flit[row * GRID_COLS + (col + GRID_COLS - 1) % GRID_COLS]),
        .h_in_ready_o (h_ready[row * GRID_COLS + (col + GRID_COLS - 1) % GRID_COLS]),
        .v_in_valid_i (v_valid[((row + GRID_ROWS - 1) % GRID_ROWS) * GRID_COLS + col]),
        .v_in_flit_i  (v_flit[((row + GRID_ROWS - 1) % GRID_ROWS) * GRID_COLS + col]),
        .v_in_ready_o (v_ready[((row + GRID_ROWS - 1) % GRID_ROWS) * GRID_COLS + col]),
        .h_out_valid_o(h_valid[row * GRID_COLS + col]),
        .h_out_flit_o (h_flit[row * GRID_COLS + col]),
        .h_out_ready_i(h_ready[row * GRID_COLS + col]),
        .v_out_valid_o(v_valid[row * GRID_COLS + col]),
        .v_out_flit_o (v_flit[row * GRID_COLS + col]),
        .v_out_ready_i(v_ready[row * GRID_COLS + col]),
        .inj_valid_i  (inj_valid_i[row * GRID_COLS + col]),
        .inj_dst_i    (inj_dst_i[row * GRID_COLS + col]),
        .inj_payload_i(inj_payload_i[row * GRID_COLS + col]),
        .inj_ready_o  (inj_ready_o[row * GRID_COLS + col]),
        .ej_valid_o   (ej_valid_o[row * GRID_COLS + col]),
        .ej_src_o     (ej_src_o[row * GRID_COLS + col]),
        .ej_payload_o (ej_payload_o[row * GRID_COLS + col]),
        .ej_ready_i   (ej_ready_i[row * GRID_COLS + col])
      );
    end
  end

endmodule

// ==== dv/tb_grid_torus.sv ====
// Torus interconnect testbench
// Directed tests with a queue scoreboard that tracks every injected flit
// until it leaves the expected ejection port

`timescale 1ns/100ps

module tb_grid_torus;
  import grid_pkg::*;

  localparam int CLK_HALF       = 50;
  localparam int CLK_PERIOD     = 2 * CLK_HALF;
  localparam int N_RANDOM       = 200;
  localparam int MAX_IN_FLIGHT  = 4;
  localparam int BP_SRC         = 0;
  localparam int BP_DST         = 4;
  localparam int BP_MAX_PACKETS = 12;
  localparam int MAX_HOPS       = (GRID_ROWS - 1) + (GRID_COLS - 1);
  localparam int N_PACKETS      = GRID_NODES * GRID_NODES + GRID_NODES + N_RANDOM + BP_MAX_PACKETS;
  localparam int WATCHDOG_CYCLES = N_PACKETS * (MAX_HOPS + 8) + 1000;

  typedef struct packed {
    logic [3:0]           src;
    logic [3:0]           dst;
    logic [PAYLOAD_W-1:0] payload;
    logic [31:0]          acc_cyc;
  } sb_entry_t;

  logic                 clk;
  logic                 rst_n;
  logic                 inj_valid  [GRID_NODES];
  node_id_t             inj_dst    [GRID_NODES];
  logic [PAYLOAD_W-1:0] inj_payload[GRID_NODES];
  logic                 inj_ready  [GRID_NODES];
  logic                 ej_valid   [GRID_NODES];
  node_id_t             ej_src     [GRID_NODES];
  logic [PAYLOAD_W-1:0] ej_payload [GRID_NODES];
  logic                 ej_ready   [GRID_NODES];

  sb_entry_t sb_q[$];
  int        cyc;
  int        errors;
  int        checks;
  integer    seed;
  bit        check_latency;

  grid_torus i_grid_torus (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .inj_valid_i  (inj_valid),
    .inj_dst_i    (inj_dst),
    .inj_payload_i(inj_payload),
    .inj_ready_o  (inj_ready),
    .ej_valid_o   (ej_valid),
    .ej_src_o     (ej_src),
    .ej_payload_o (ej_payload),
    .ej_ready_i   (ej_ready)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  initial cyc = 0;
  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic int node_num(input node_id_t id);
    return id.row * GRID_COLS + id.col;
  endfunction

  function automatic node_id_t to_id(input int n);
    node_id_t id;
    id.row = ROW_W'(n / GRID_COLS);
    id.col = COL_W'(n % GRID_COLS);
    return id;
  endfunction

  // Column distance plus row distance along the one-way rings
  function automatic int hop_count(input int s, input int d);
    return ((d % GRID_COLS - s % GRID_COLS + GRID_COLS) % GRID_COLS) +
           ((d / GRID_COLS - s / GRID_COLS + GRID_ROWS) % GRID_ROWS);
  endfunction

  task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                input string msg);
    checks++;
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s, got %0d, expected %0d", $time, msg, actual, expected);
      errors++;
    end
  endtask

  // Oldest flit of the same pair must be the one that leaves
  task automatic match_ejection(input int n);
    int        src;
    int        idx;
    sb_entry_t entry;
    src = node_num(ej_src[n]);
    idx = -1;
    for (int i = 0; i < sb_q.size(); i++) begin
      if (idx < 0 && sb_q[i].src == src && sb_q[i].dst == n) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("Error at %0t: node %0d ejected a flit from node %0d that nobody sent there",
               $time, n, src);
      errors++;
    end else begin
      entry = sb_q[idx];
      sb_q.delete(idx);
      compare_values(ej_payload[n], entry.payload, $sformatf("payload %0d->%0d", src, n));
      if (check_latency) begin
        compare_values(cyc - entry.acc_cyc, hop_count(entry.src, entry.dst),
                       $sformatf("latency %0d->%0d", src, n));
      end
    end
  endtask

  // Both handshakes are sampled half a cycle before the edge that completes them
  always @(negedge clk) begin
    if (rst_n) begin
      for (int n = 0; n < GRID_NODES; n++) begin
        if (inj_valid[n] && inj_ready[n]) begin
          sb_q.push_back({4'(n), 4'(node_num(inj_dst[n])), inj_payload[n], 32'(cyc)});
        end
      end
      for (int n = 0; n < GRID_NODES; n++) begin
        if (ej_valid[n] && ej_ready[n]) begin
          match_ejection(n);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic drive_flit(input int src, input int dst, input logic [PAYLOAD_W-1:0] payload);
    inj_valid[src]   <= 1'b1;
    inj_dst[src]     <= to_id(dst);
    inj_payload[src] <= payload;
  endtask

  task automatic wait_accept(input int src, input int max_cycles, output bit accepted);
    int waited;
    accepted = 1'b0;
    waited   = 0;
    while (!accepted && waited < max_cycles) begin
      @(negedge clk);
      accepted = inj_ready[src];
      waited++;
    end
    if (accepted) begin
      @(posedge clk);
      inj_valid[src] <= 1'b0;
    end
  endtask

  task automatic send_flit(input int src, input int dst, input logic [PAYLOAD_W-1:0] payload);
    bit ok;
    @(posedge clk);
    drive_flit(src, dst, payload);
    wait_accept(src, 100, ok);
    if (!ok) begin
      $display("Error at %0t: injection port %0d never became ready", $time, src);
      errors++;
    end
  endtask

  task automatic wait_drained(input int max_cycles, input string what);
    int waited;
    waited = 0;
    while (sb_q.size() != 0 && waited < max_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (sb_q.size() != 0) begin
      $display("Error at %0t: %0d flits never delivered during %s", $time, sb_q.size(), what);
      errors++;
      sb_q.delete();
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    for (int n = 0; n < GRID_NODES; n++) begin
      compare_values(ej_valid[n], 1'b0, $sformatf("ej_valid after reset, node %0d", n));
      compare_values(inj_ready[n], 1'b1, $sformatf("inj_ready after reset, node %0d", n));
    end
  endtask

  task automatic test_all_pairs();
    check_latency = 1'b1;
    for (int s = 0; s < GRID_NODES; s++) begin
      for (int d = 0; d < GRID_NODES; d++) begin
        send_flit(s, d, PAYLOAD_W'($random(seed)));
        wait_drained(MAX_HOPS + 10, $sformatf("pair %0d->%0d", s, d));
      end
    end
    check_latency = 1'b0;
  endtask

  // Own-node flit must show up at ejection while still being injected
  task automatic test_self_delivery();
    logic [PAYLOAD_W-1:0] payload;
    check_latency = 1'b1;
    for (int n = 0; n < GRID_NODES; n++) begin
      payload = $random(seed);
      @(posedge clk);
      drive_flit(n, n, payload);
      @(negedge clk);
      compare_values(inj_ready[n], 1'b1, $sformatf("self inj_ready, node %0d", n));
      compare_values(ej_valid[n], 1'b1, $sformatf("self ej_valid, node %0d", n));
      compare_values(node_num(ej_src[n]), n, $sformatf("self ej_src, node %0d", n));
      compare_values(ej_payload[n], payload, $sformatf("self ej_payload, node %0d", n));
      @(posedge clk);
      inj_valid[n] <= 1'b0;
      wait_drained(5, $sformatf("self delivery at node %0d", n));
    end
    check_latency = 1'b0;
  endtask

  task automatic test_random_traffic(input int n_flits);
    int sent;
    int pending;
    int src;
    int guard;
    bit acc [GRID_NODES];
    sent    = 0;
    pending = 0;
    guard   = 0;
    while ((sent < n_flits || pending != 0) && guard < n_flits * 20) begin
      @(negedge clk);
      for (int n = 0; n < GRID_NODES; n++) begin
        acc[n] = inj_valid[n] && inj_ready[n];
      end
      @(posedge clk);
      pending = 0;
      for (int n = 0; n < GRID_NODES; n++) begin
        if (acc[n]) begin
          inj_valid[n] <= 1'b0;
        end else if (inj_valid[n]) begin
          pending++;
        end
      end
      // At most one new flit per cycle and only from an idle source
      if (sent < n_flits && sb_q.size() + pending < MAX_IN_FLIGHT) begin
        src = {$random(seed)} % GRID_NODES;
        if (!inj_valid[src] || acc[src]) begin
          drive_flit(src, {$random(seed)} % GRID_NODES, PAYLOAD_W'($random(seed)));
          sent++;
          pending++;
        end
      end
      guard++;
    end
    if (sent < n_flits || pending != 0) begin
      $display("Error at %0t: random traffic stalled after %0d flits", $time, sent);
      errors++;
    end
    wait_drained(200, "random traffic");
  endtask

  task automatic test_back_pressure();
    bit ok;
    bit dropped;
    int sent;
    sent    = 0;
    dropped = 1'b0;
    @(posedge clk);
    ej_ready[BP_DST] <= 1'b0;
    while (!dropped && sent < BP_MAX_PACKETS) begin
      @(posedge clk);
      drive_flit(BP_SRC, BP_DST, PAYLOAD_W'($random(seed)));
      wait_accept(BP_SRC, 8, ok);
      if (ok) begin
        sent++;
      end else begin
        dropped = 1'b1;
      end
    end
    if (!dropped) begin
      $display("Error at %0t: inj_ready at node %0d never dropped under back-pressure",
               $time, BP_SRC);
      errors++;
    end
    @(negedge clk);
    for (int n = 0; n < GRID_NODES; n++) begin
      compare_values(ej_valid[n], n == BP_DST, $sformatf("ej_valid while held, node %0d", n));
    end
    @(posedge clk);
    ej_ready[BP_DST] <= 1'b1;
    if (dropped) begin
      wait_accept(BP_SRC, 50, ok);
      if (!ok) begin
        $display("Error at %0t: node %0d stuck after back-pressure release", $time, BP_SRC);
        errors++;
      end
    end
    wait_drained(100, "back-pressure release");
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    seed          = 32'h8e38_d876;
    errors        = 0;
    checks        = 0;
    check_latency = 1'b0;
    rst_n         = 1'b0;
    for (int n = 0; n < GRID_NODES; n++) begin
      inj_valid[n]   = 1'b0;
      inj_dst[n]     = '0;
      inj_payload[n] = '0;
      ej_ready[n]    = 1'b1;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_all_pairs();
    test_self_delivery();
    test_random_traffic(N_RANDOM);
    test_back_pressure();
    repeat (5) @(posedge clk);
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/grid_pkg.sv
logic/grid_link_buf.sv
logic/grid_node_switch.sv
logic/grid_node.sv
logic/grid_torus.sv
dv/tb_grid_torus.sv
